// File: Bender.yml
package:
  name: csr_subsys

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/csr_pkg.sv
      - hdl/csr_issue_fifo.sv
      - hdl/csr_issue.sv
      - hdl/csr_exec.sv
      - hdl/phy_regfile.sv
      - hdl/csr_subsys.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - bench/tb_csr_subsys.sv

// File: bench/tb_csr_subsys.sv
/* CSR subsystem testbench
   Directed tests of issue order, hazards, CSR read-modify-write and queue back-pressure */
`include "csr_macros.svh"

module tb_csr_subsys;
	timeunit 1ns;
	timeprecision 100ps;

	import csr_pkg::*;

	// Each test needs well under 200 cycles, so six tests and reset fit with room to spare
	localparam int MAX_CYCLES = 2000;
	localparam int WB_WAIT    = 12;
	localparam logic [2:0] FN_W = 3'(1 << `CSR_FN_RW);
	localparam logic [2:0] FN_S = 3'(1 << `CSR_FN_RS);
	localparam logic [2:0] FN_C = 3'(1 << `CSR_FN_RC);
	localparam logic [11:0] CSR_UNKNOWN = 12'h7c0;

	logic               CLK = 1'b0;
	logic               rst_n;
	logic               push;
	logic [2:0]         csr_fn;
	logic               imm_sel;
	logic [`XLEN-1:0]   pc;
	logic [11:0]        csr_addr;
	logic [`PRF_AW-1:0] rd;
	csr_src_u           src;
	logic               full;
	logic [`XLEN-1:0]   commit_pc;
	logic               rename_clr;
	logic [`PRF_AW-1:0] rename_idx;
	logic               ext_wb_valid;
	logic [`PRF_AW-1:0] ext_wb_idx;
	logic [`XLEN-1:0]   ext_wb_data;
	logic [`PRF_AW-1:0] rd_idx;
	logic [`XLEN-1:0]   rd_data;
	logic               wb_valid;
	logic [`PRF_AW-1:0] wb_rd;
	logic [`XLEN-1:0]   wb_data;

	logic [`XLEN-1:0] model [4];
	logic [`XLEN-1:0] next_pc;
	int               errors;
	int               tests_run;
	int               tests_failed;
	int               cycles;

	csr_subsys i_csr_subsys (.*);

	always #5 CLK = ~CLK;

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: the run went past %0d cycles", MAX_CYCLES);
			$display("Test FAILED");
			$finish;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference model of the CSR file
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic logic [11:0] csr_addr_at(input int i);
		case (i)
			0:       return `CSR_MSCRATCH;
			1:       return `CSR_MEPC;
			2:       return `CSR_MCAUSE;
			default: return `CSR_MTVEC;
		endcase
	endfunction

	// Slot -1 stands for an address the CSR file does not hold
	function automatic int model_slot(input logic [11:0] addr);
		int slot;
		slot = -1;
		for (int i = 0; i < 4; i++)
			if (addr == csr_addr_at(i))
				slot = i;
		return slot;
	endfunction

	function automatic logic [`XLEN-1:0] rmw(input logic [2:0] fn,
			input logic [`XLEN-1:0] old_v, input logic [`XLEN-1:0] op);
		case (fn)
			FN_W:    return op;
			FN_S:    return old_v | op;
			FN_C:    return old_v & ~op;
			default: return old_v;
		endcase
	endfunction

	function automatic logic [2:0] fn_at(input int k);
		return (k == 0) ? FN_W : (k == 1) ? FN_S : FN_C;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Drivers and checkers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic report_mismatch(input string name, input logic [`XLEN-1:0] got,
			input logic [`XLEN-1:0] exp);
		$display("[ERROR] %s = %h, expected %h", name, got, exp);
		errors++;
	endtask

	task automatic note_failure(input string msg);
		$display("%s", msg);
		errors++;
	endtask

	task automatic close_test(input string name, input int errors_before);
		tests_run++;
		if (errors != errors_before)
			tests_failed++;
		$display("%-18s finished with %0d errors", name, errors - errors_before);
	endtask

	// The entry lands in the queue on the second rising edge
	task automatic push_entry(input logic [2:0] fn, input logic isel,
			input logic [`XLEN-1:0] epc, input logic [11:0] addr,
			input logic [`PRF_AW-1:0] dst, input logic [`PRF_AW-1:0] s, input bit commit_now);
		@(posedge CLK);
		push <= 1'b1;
		csr_fn <= fn;
		imm_sel <= isel;
		pc <= epc;
		csr_addr <= addr;
		rd <= dst;
		src <= s;
		if (commit_now)
			commit_pc <= epc;
		@(posedge CLK);
		push <= 1'b0;
	endtask

	task automatic ext_write(input logic [`PRF_AW-1:0] idx, input logic [`XLEN-1:0] data);
		@(posedge CLK);
		ext_wb_valid <= 1'b1;
		ext_wb_idx <= idx;
		ext_wb_data <= data;
		@(posedge CLK);
		ext_wb_valid <= 1'b0;
	endtask

	task automatic clear_log(input logic [`PRF_AW-1:0] idx);
		@(posedge CLK);
		rename_clr <= 1'b1;
		rename_idx <= idx;
		@(posedge CLK);
		rename_clr <= 1'b0;
	endtask

	// Updates the model and queues the instruction, returning its pc and expected old value
	task automatic start_csr(input logic [2:0] fn, input logic isel, input logic [11:0] addr,
			input logic [`PRF_AW-1:0] dst, input logic [`PRF_AW-1:0] s,
			input logic [`XLEN-1:0] op, input bit commit_now,
			output logic [`XLEN-1:0] epc, output logic [`XLEN-1:0] exp_old);
		int slot;
		slot = model_slot(addr);
		exp_old = (slot < 0) ? '0 : model[slot];
		if (slot >= 0)
			model[slot] = rmw(fn, exp_old, op);
		next_pc = next_pc + 64'd4;
		epc = next_pc;
		push_entry(fn, isel, epc, addr, dst, s, commit_now);
	endtask

	task automatic wait_wb(output int lat);
		lat = 0;
		do begin
			@(negedge CLK);
			lat++;
		end while (!wb_valid && lat < WB_WAIT);
		if (!wb_valid)
			note_failure($sformatf("wb_valid did not arrive within %0d cycles", WB_WAIT));
	endtask

	// Called right after the edge that starts cycle N, where the entry becomes free to issue
	task automatic finish_csr(input logic [`PRF_AW-1:0] dst, input logic [`XLEN-1:0] exp_old);
		int lat;
		if (dst[`PRF_AW-1 -: 5] == 5'd0) begin
			repeat (4) begin
				@(negedge CLK);
				if (wb_valid)
					note_failure("wb_valid raised for a destination x0");
			end
		end else begin
			wait_wb(lat);
			if (wb_valid) begin
				if (lat != 3)
					note_failure($sformatf("write-back came in cycle N+%0d, not N+2", lat - 1));
				if (wb_rd !== dst)
					report_mismatch("wb_rd", 64'(wb_rd), 64'(dst));
				if (wb_data !== exp_old)
					report_mismatch("wb_data", wb_data, exp_old);
				@(posedge CLK);
				rd_idx <= dst;
				@(negedge CLK);
				if (rd_data !== exp_old)
					report_mismatch("rd_data", rd_data, exp_old);
			end
		end
	endtask

	task automatic run_csr(input logic [2:0] fn, input logic isel, input logic [11:0] addr,
			input logic [`PRF_AW-1:0] dst, input logic [`PRF_AW-1:0] s,
			input logic [`XLEN-1:0] op);
		logic [`XLEN-1:0] epc;
		logic [`XLEN-1:0] exp_old;
		start_csr(fn, isel, addr, dst, s, op, 1'b1, epc, exp_old);
		finish_csr(dst, exp_old);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic imm_rmw_sequence();
		logic [4:0] uimm;
		int e0;
		e0 = errors;
		for (int i = 0; i < 4; i++) begin
			for (int k = 0; k < 3; k++) begin
				uimm = 5'($urandom);
				run_csr(fn_at(k), 1'b1, csr_addr_at(i), {5'(i + 1), 2'(k)}, {uimm, 2'b00},
					64'(uimm));
			end
			// Set with zero reads the CSR without changing it
			run_csr(FN_S, 1'b1, csr_addr_at(i), {5'(i + 1), 2'd3}, '0, '0);
		end
		close_test("imm_rmw", e0);
	endtask

	task automatic reg_operand_rmw();
		logic [`PRF_AW-1:0] sidx;
		logic [`XLEN-1:0]   val;
		int e0;
		e0 = errors;
		sidx = {5'd12, 2'd1};
		for (int k = 0; k < 3; k++) begin
			val = {$urandom, $urandom};
			ext_write(sidx, val);
			run_csr(fn_at(k), 1'b0, `CSR_MEPC, {5'd20, 2'(k)}, sidx, val);
		end
		run_csr(FN_S, 1'b1, `CSR_MEPC, {5'd20, 2'd3}, '0, '0);
		close_test("reg_operand", e0);
	endtask

	task automatic commit_ordering();
		logic [`XLEN-1:0] epc;
		logic [`XLEN-1:0] exp_old;
		int e0;
		e0 = errors;
		start_csr(FN_W, 1'b1, `CSR_MSCRATCH, {5'd5, 2'd0}, {5'd19, 2'b00}, 64'd19, 1'b0,
			epc, exp_old);
		repeat (6) begin
			@(negedge CLK);
			if (wb_valid)
				note_failure("wb_valid raised before commit_pc reached the entry");
		end
		@(posedge CLK);
		commit_pc <= epc;
		finish_csr({5'd5, 2'd0}, exp_old);
		close_test("commit_order", e0);
	endtask

	task automatic raw_hazard();
		logic [`PRF_AW-1:0] sidx;
		logic [`XLEN-1:0]   val;
		logic [`XLEN-1:0]   epc;
		logic [`XLEN-1:0]   exp_old;
		int e0;
		e0 = errors;
		sidx = {5'd7, 2'd2};
		val = {$urandom, $urandom};
		clear_log(sidx);
		start_csr(FN_W, 1'b0, `CSR_MTVEC, {5'd9, 2'd0}, sidx, val, 1'b1, epc, exp_old);
		repeat (6) begin
			@(negedge CLK);
			if (wb_valid)
				note_failure("wb_valid raised while the source was not written back");
		end
		ext_write(sidx, val);
		finish_csr({5'd9, 2'd0}, exp_old);
		run_csr(FN_S, 1'b1, `CSR_MTVEC, {5'd9, 2'd1}, '0, '0);
		close_test("raw_hazard", e0);
	endtask

	task automatic x0_and_unknown();
		int e0;
		e0 = errors;
		run_csr(FN_W, 1'b1, `CSR_MSCRATCH, {5'd0, 2'd3}, {5'd21, 2'b00}, 64'd21);
		run_csr(FN_W, 1'b1, CSR_UNKNOWN, {5'd3, 2'd1}, {5'd31, 2'b00}, 64'd31);
		run_csr(FN_S, 1'b1, CSR_UNKNOWN, {5'd3, 2'd2}, '0, '0);
		for (int i = 0; i < 4; i++)
			run_csr(FN_S, 1'b1, csr_addr_at(i), {5'd4, 2'(i)}, '0, '0);
		close_test("x0_and_unknown", e0);
	endtask

	task automatic queue_backpressure();
		logic [`XLEN-1:0]   pcs  [`ISSUE_DEPTH];
		logic [`XLEN-1:0]   olds [`ISSUE_DEPTH];
		logic [`PRF_AW-1:0] dsts [`ISSUE_DEPTH];
		int e0;
		e0 = errors;
		for (int k = 0; k < `ISSUE_DEPTH; k++) begin
			dsts[k] = {5'(k + 24), 2'd0};
			start_csr(FN_W, 1'b1, `CSR_MCAUSE, dsts[k], {5'(k + 1), 2'b00}, 64'(k + 1), 1'b0,
				pcs[k], olds[k]);
		end
		@(negedge CLK);
		if (!full)
			note_failure("queue did not report full after filling it");
		// This entry must be dropped, so the model does not see it
		next_pc = next_pc + 64'd4;
		push_entry(FN_W, 1'b1, next_pc, `CSR_MCAUSE, {5'd30, 2'd0}, {5'd17, 2'b00}, 1'b0);
		for (int k = 0; k < `ISSUE_DEPTH; k++) begin
			@(posedge CLK);
			commit_pc <= pcs[k];
			finish_csr(dsts[k], olds[k]);
		end
		@(posedge CLK);
		commit_pc <= next_pc;
		repeat (5) begin
			@(negedge CLK);
			if (wb_valid)
				note_failure("a push made while the queue was full produced a result");
		end
		close_test("backpressure", e0);
	endtask

	initial begin
		void'($urandom(38));
		rst_n = 1'b0;
		push = 1'b0;
		csr_fn = '0;
		imm_sel = 1'b0;
		pc = '0;
		csr_addr = '0;
		rd = '0;
		src = '0;
		commit_pc = '0;
		rename_clr = 1'b0;
		rename_idx = '0;
		ext_wb_valid = 1'b0;
		ext_wb_idx = '0;
		ext_wb_data = '0;
		rd_idx = '0;
		next_pc = 64'h8000_0000;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		cycles = 0;
		for (int i = 0; i < 4; i++)
			model[i] = '0;

		repeat (8) @(posedge CLK);
		rst_n <= 1'b1;

		imm_rmw_sequence();
		reg_operand_rmw();
		commit_ordering();
		raw_hazard();
		x0_and_unknown();
		queue_backpressure();

		@(posedge CLK);
		$display("Tests run: %0d, tests failed: %0d, errors: %0d", tests_run, tests_failed,
			errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// File: hdl/csr_exec.sv
/* CSR execute unit
   Machine CSR file with read-modify-write, returns the old value to rd */
`include "csr_macros.svh"

module csr_exec (
	input  logic               CLK,
	input  logic               rst_n,
	input  logic               exe_valid,
	input  logic [2:0]         exe_fn,
	input  logic [`PRF_AW-1:0] exe_rd,
	input  logic [`XLEN-1:0]   exe_op,
	input  logic [11:0]        exe_addr,
	output logic               wb_valid,
	output logic [`PRF_AW-1:0] wb_rd,
	output logic [`XLEN-1:0]   wb_data
);

	logic [`XLEN-1:0] mscratch;
	logic [`XLEN-1:0] mepc;
	logic [`XLEN-1:0] mcause;
	logic [`XLEN-1:0] mtvec;

	logic [`XLEN-1:0] old_val;
	logic [`XLEN-1:0] new_val;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Read and modify
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Addresses outside the file read as zero
	always_comb begin
		case (exe_addr)
			`CSR_MSCRATCH: old_val = mscratch;
			`CSR_MEPC:     old_val = mepc;
			`CSR_MCAUSE:   old_val = mcause;
			`CSR_MTVEC:    old_val = mtvec;
			default:       old_val = '0;
		endcase
	end

	assign new_val = ({`XLEN{exe_fn[`CSR_FN_RW]}} & exe_op)
	               | ({`XLEN{exe_fn[`CSR_FN_RS]}} & (old_val | exe_op))
	               | ({`XLEN{exe_fn[`CSR_FN_RC]}} & (old_val & ~exe_op));

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Write
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			mscratch <= '0;
			mepc     <= '0;
			mcause   <= '0;
			mtvec    <= '0;
		end else if (exe_valid) begin
			// Unknown addresses match no case and drop the write
			case (exe_addr)
				`CSR_MSCRATCH: mscratch <= new_val;
				`CSR_MEPC:     mepc     <= new_val;
				`CSR_MCAUSE:   mcause   <= new_val;
				`CSR_MTVEC:    mtvec    <= new_val;
				default:       ;
			endcase
		end
	end

	// No write-back for x0 as destination
	always_ff @(posedge CLK) begin
		if (!rst_n)
			wb_valid <= 1'b0;
		else
			wb_valid <= exe_valid & (exe_rd[`PRF_AW-1 -: 5] != 5'd0);
	end

	always_ff @(posedge CLK) begin
		if (exe_valid) begin
			wb_rd   <= exe_rd;
			wb_data <= old_val;
		end
	end

	a_fn_onehot: assert property (
		@(posedge CLK) disable iff (!rst_n) exe_valid |-> $onehot(exe_fn)
	) else $error("CSR exec: function field is not one-hot");

endmodule

// File: hdl/csr_issue.sv
/* CSR issue stage
   Releases the queue head at commit once its source is written back */
`include "csr_macros.svh"

module csr_issue (
	input  logic               CLK,
	input  logic               rst_n,
	output logic               fifo_pop,
	input  logic               fifo_empty,
	input  logic [2:0]         head_fn,
	input  logic               head_imm_sel,
	input  logic [`XLEN-1:0]   head_pc,
	input  logic [11:0]        head_addr,
	input  logic [`PRF_AW-1:0] head_rd,
	input  csr_pkg::csr_src_u  head_src,
	input  logic [`XLEN-1:0]   commit_pc,
	output logic [`PRF_AW-1:0] rf_raddr,
	input  logic [`XLEN-1:0]   rf_rdata,
	input  logic               rf_ready,
	output logic               exe_valid,
	output logic [2:0]         exe_fn,
	output logic [`PRF_AW-1:0] exe_rd,
	output logic [`XLEN-1:0]   exe_op,
	output logic [11:0]        exe_addr
);

	logic             at_commit;
	logic             src_ready;
	logic [`XLEN-1:0] operand;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Issue condition
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// CSR instructions are never rolled back, so all older ones must have committed
	assign at_commit = (head_pc == commit_pc);

	// Register x0 never waits on the write-back log
	assign rf_raddr  = head_src.rs;
	assign src_ready = head_imm_sel | rf_ready | (head_src.rs.arch == 5'd0);

	// Execute is always ready, so nothing stalls the pop
	assign fifo_pop = ~fifo_empty & at_commit & src_ready;

	assign operand = head_imm_sel ? {{(`XLEN - 5){1'b0}}, head_src.imm.uimm} : rf_rdata;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Execute packet
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge CLK) begin
		if (!rst_n)
			exe_valid <= 1'b0;
		else
			exe_valid <= fifo_pop;
	end

	always_ff @(posedge CLK) begin
		if (fifo_pop) begin
			exe_fn   <= head_fn;
			exe_rd   <= head_rd;
			exe_op   <= operand;
			exe_addr <= head_addr;
		end
	end

	// A waiting head entry must hold still until it is popped
	a_head_stable: assert property (
		@(posedge CLK) disable iff (!rst_n) (!fifo_empty && !fifo_pop) |=> $stable(head_pc)
	) else $error("CSR issue: queue head changed while waiting to issue");

endmodule

// File: hdl/csr_issue_fifo.sv
/* CSR issue queue
   In-order circular buffer of CSR instructions between dispatch and issue */
`include "csr_macros.svh"

module csr_issue_fifo (
	input  logic               CLK,
	input  logic               rst_n,
	input  logic               push,
	input  logic [2:0]         in_fn,
	input  logic               in_imm_sel,
	input  logic [`XLEN-1:0]   in_pc,
	input  logic [11:0]        in_addr,
	input  logic [`PRF_AW-1:0] in_rd,
	input  csr_pkg::csr_src_u  in_src,
	output logic               full,
	output logic               empty,
	input  logic               pop,
	output logic [2:0]         out_fn,
	output logic               out_imm_sel,
	output logic [`XLEN-1:0]   out_pc,
	output logic [11:0]        out_addr,
	output logic [`PRF_AW-1:0] out_rd,
	output csr_pkg::csr_src_u  out_src
);
	import csr_pkg::*;

	localparam int PW = $clog2(`ISSUE_DEPTH);
	localparam int CW = $clog2(`ISSUE_DEPTH + 1);

	logic [2:0]         fn_mem   [`ISSUE_DEPTH];
	logic               imm_mem  [`ISSUE_DEPTH];
	logic [`XLEN-1:0]   pc_mem   [`ISSUE_DEPTH];
	logic [11:0]        addr_mem [`ISSUE_DEPTH];
	logic [`PRF_AW-1:0] rd_mem   [`ISSUE_DEPTH];
	csr_src_u           src_mem  [`ISSUE_DEPTH];

	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic          do_push;
	logic          do_pop;

	assign full    = (count == CW'(`ISSUE_DEPTH));
	assign empty   = (count == '0);
	assign do_push = push & ~full;
	assign do_pop  = pop & ~empty;

	// Head of the queue is visible without a read strobe
	assign out_fn      = fn_mem[rd_ptr];
	assign out_imm_sel = imm_mem[rd_ptr];
	assign out_pc      = pc_mem[rd_ptr];
	assign out_addr    = addr_mem[rd_ptr];
	assign out_rd      = rd_mem[rd_ptr];
	assign out_src     = src_mem[rd_ptr];

	always_ff @(posedge CLK) begin
		if (do_push) begin
			fn_mem[wr_ptr]   <= in_fn;
			imm_mem[wr_ptr]  <= in_imm_sel;
			pc_mem[wr_ptr]   <= in_pc;
			addr_mem[wr_ptr] <= in_addr;
			rd_mem[wr_ptr]   <= in_rd;
			src_mem[wr_ptr]  <= in_src;
		end
	end

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == PW'(`ISSUE_DEPTH - 1)) ? '0 : wr_ptr + PW'(1);
			if (do_pop)
				rd_ptr <= (rd_ptr == PW'(`ISSUE_DEPTH - 1)) ? '0 : rd_ptr + PW'(1);
			// A push and a pop in one cycle leave the count as it is
			case ({do_push, do_pop})
				2'b10:   count <= count + CW'(1);
				2'b01:   count <= count - CW'(1);
				default: count <= count;
			endcase
		end
	end

	// Dispatch should respect full, the entry is dropped otherwise
	a_no_push_full: assert property (@(posedge CLK) disable iff (!rst_n) !(push && full))
		else $warning("CSR issue queue: push while full dropped");

	a_no_pop_empty: assert property (@(posedge CLK) disable iff (!rst_n) !(pop && empty))
		else $error("CSR issue queue: pop while empty");

endmodule

// File: hdl/csr_macros.svh
/* CSR path sizes
   Data width, rename banks, issue queue depth and machine CSR addresses */
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

// Data path width of the core
`define XLEN 64

// A physical index is the architectural number with RB bank bits below it
`define RB 2
`define RP (1 << `RB)
`define PRF_AW (5 + `RB)

// Depth of the in-order CSR issue queue
`define ISSUE_DEPTH 4

// Bit positions inside the one-hot CSR function field
`define CSR_FN_RW 2
`define CSR_FN_RS 1
`define CSR_FN_RC 0

// Machine CSRs held by the execute unit
`define CSR_MSCRATCH 12'h340
`define CSR_MEPC     12'h341
`define CSR_MCAUSE   12'h342
`define CSR_MTVEC    12'h305

`endif

// File: hdl/csr_pkg.sv
/* CSR path types
   Two views of the 7-bit source field of a CSR instruction */
`include "csr_macros.svh"

package csr_pkg;

	// Renamed source register, architectural number above the bank
	typedef struct packed {
		logic [4:0]     arch;
		logic [`RB-1:0] bank;
	} src_reg_t;

	// Zero-extended 5-bit immediate, the bank bits carry nothing
	typedef struct packed {
		logic [4:0]     uimm;
		logic [`RB-1:0] pad;
	} src_imm_t;

	// The immediate select flag of the entry picks the view
	typedef union packed {
		src_reg_t rs;
		src_imm_t imm;
	} csr_src_u;

endpackage

// File: hdl/csr_subsys.sv
/* CSR subsystem top
   Issue queue, commit-ordered issue, CSR execute and physical register file */
`include "csr_macros.svh"

module csr_subsys (
	input  logic               CLK,
	input  logic               rst_n,
	input  logic               push,
	input  logic [2:0]         csr_fn,
	input  logic               imm_sel,
	input  logic [`XLEN-1:0]   pc,
	input  logic [11:0]        csr_addr,
	input  logic [`PRF_AW-1:0] rd,
	input  csr_pkg::csr_src_u  src,
	output logic               full,
	input  logic [`XLEN-1:0]   commit_pc,
	input  logic               rename_clr,
	input  logic [`PRF_AW-1:0] rename_idx,
	input  logic               ext_wb_valid,
	input  logic [`PRF_AW-1:0] ext_wb_idx,
	input  logic [`XLEN-1:0]   ext_wb_data,
	input  logic [`PRF_AW-1:0] rd_idx,
	output logic [`XLEN-1:0]   rd_data,
	output logic               wb_valid,
	output logic [`PRF_AW-1:0] wb_rd,
	output logic [`XLEN-1:0]   wb_data
);
	import csr_pkg::*;

	// Queue head
	logic               fifo_pop;
	logic               fifo_empty;
	logic [2:0]         head_fn;
	logic               head_imm_sel;
	logic [`XLEN-1:0]   head_pc;
	logic [11:0]        head_addr;
	logic [`PRF_AW-1:0] head_rd;
	csr_src_u           head_src;

	// Operand read
	logic [`PRF_AW-1:0] rf_raddr;
	logic [`XLEN-1:0]   rf_rdata;
	logic               rf_ready;

	// Execute packet
	logic               exe_valid;
	logic [2:0]         exe_fn;
	logic [`PRF_AW-1:0] exe_rd;
	logic [`XLEN-1:0]   exe_op;
	logic [11:0]        exe_addr;

	csr_issue_fifo i_csr_issue_fifo (
		.CLK         (CLK),
		.rst_n       (rst_n),
		.push        (push),
		.in_fn       (csr_fn),
		.in_imm_sel  (imm_sel),
		.in_pc       (pc),
		.in_addr     (csr_addr),
		.in_rd       (rd),
		.in_src      (src),
		.full        (full),
		.empty       (fifo_empty),
		.pop         (fifo_pop),
		.out_fn      (head_fn),
		.out_imm_sel (head_imm_sel),
		.out_pc      (head_pc),
		.out_addr    (head_addr),
		.out_rd      (head_rd),
		.out_src     (head_src)
	);

	csr_issue i_csr_issue (
		.CLK          (CLK),
		.rst_n        (rst_n),
		.fifo_pop     (fifo_pop),
		.fifo_empty   (fifo_empty),
		.head_fn      (head_fn),
		.head_imm_sel (head_imm_sel),
		.head_pc      (head_pc),
		.head_addr    (head_addr),
		.head_rd      (head_rd),
		.head_src     (head_src),
		.commit_pc    (commit_pc),
		.rf_raddr     (rf_raddr),
		.rf_rdata     (rf_rdata),
		.rf_ready     (rf_ready),
		.exe_valid    (exe_valid),
		.exe_fn       (exe_fn),
		.exe_rd       (exe_rd),
		.exe_op       (exe_op),
		.exe_addr     (exe_addr)
	);

	csr_exec i_csr_exec (
		.CLK       (CLK),
		.rst_n     (rst_n),
		.exe_valid (exe_valid),
		.exe_fn    (exe_fn),
		.exe_rd    (exe_rd),
		.exe_op    (exe_op),
		.exe_addr  (exe_addr),
		.wb_valid  (wb_valid),
		.wb_rd     (wb_rd),
		.wb_data   (wb_data)
	);

	phy_regfile i_phy_regfile (
		.CLK       (CLK),
		.rst_n     (rst_n),
		.raddr_a   (rf_raddr),
		.rdata_a   (rf_rdata),
		.ready_a   (rf_ready),
		.raddr_b   (rd_idx),
		.rdata_b   (rd_data),
		.csr_we    (wb_valid),
		.csr_widx  (wb_rd),
		.csr_wdata (wb_data),
		.ext_we    (ext_wb_valid),
		.ext_widx  (ext_wb_idx),
		.ext_wdata (ext_wb_data),
		.clr       (rename_clr),
		.clr_idx   (rename_idx)
	);

endmodule

// File: hdl/phy_regfile.sv
/* Physical integer register file
   Write-back log per register, CSR and external write ports, two read ports */
`include "csr_macros.svh"

module phy_regfile (
	input  logic               CLK,
	input  logic               rst_n,
	input  logic [`PRF_AW-1:0] raddr_a,
	output logic [`XLEN-1:0]   rdata_a,
	output logic               ready_a,
	input  logic [`PRF_AW-1:0] raddr_b,
	output logic [`XLEN-1:0]   rdata_b,
	input  logic               csr_we,
	input  logic [`PRF_AW-1:0] csr_widx,
	input  logic [`XLEN-1:0]   csr_wdata,
	input  logic               ext_we,
	input  logic [`PRF_AW-1:0] ext_widx,
	input  logic [`XLEN-1:0]   ext_wdata,
	input  logic               clr,
	input  logic [`PRF_AW-1:0] clr_idx
);

	localparam int NREG = 32 * `RP;

	logic [`XLEN-1:0] regs [NREG];
	logic [NREG-1:0]  wb_log;
	logic             ext_ok;

	// The CSR write takes the index when both ports hit it
	assign ext_ok = ext_we & ~(csr_we & (csr_widx == ext_widx));

	// All banks of x0 read as zero
	assign rdata_a = (raddr_a[`PRF_AW-1 -: 5] == 5'd0) ? '0 : regs[raddr_a];
	assign rdata_b = (raddr_b[`PRF_AW-1 -: 5] == 5'd0) ? '0 : regs[raddr_b];
	assign ready_a = wb_log[raddr_a];

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			for (int i = 0; i < NREG; i++)
				regs[i] <= '0;
		end else begin
			if (ext_ok)
				regs[ext_widx] <= ext_wdata;
			if (csr_we)
				regs[csr_widx] <= csr_wdata;
		end
	end

	// Later assignments win, so a set overrides a clear of the same bit
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			wb_log <= '1;
		end else begin
			if (clr)
				wb_log[clr_idx] <= 1'b0;
			if (ext_we)
				wb_log[ext_widx] <= 1'b1;
			if (csr_we)
				wb_log[csr_widx] <= 1'b1;
		end
	end

	// Other units must not write a register owned by a CSR instruction
	a_no_write_clash: assert property (
		@(posedge CLK) disable iff (!rst_n) (csr_we && ext_we) |-> (csr_widx != ext_widx)
	) else $error("Register file: CSR and external write to the same index");

endmodule

// File: tb.f
+incdir+hdl
hdl/csr_pkg.sv
hdl/csr_issue_fifo.sv
hdl/csr_issue.sv
hdl/csr_exec.sv
hdl/phy_regfile.sv
hdl/csr_subsys.sv
bench/tb_csr_subsys.sv
